//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pcu
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- project.f
source/pcu_pkg.sv
source/input_filter.sv
source/fault_latch.sv
source/cmd_decoder.sv
source/bridge_driver.sv
source/charge_sequencer.sv
source/pcu_top.sv
tb/pcu_checker.sv
tb/tb_pcu.sv

//--- source/bridge_driver.sv
module bridge_driver (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 i_load,
  input  pcu_pkg::bridge_pat_t i_pat,
  input  logic                 i_shutdown,
  input  logic                 i_fault,
  output pcu_pkg::leg_t        o_top,
  output pcu_pkg::leg_t        o_bot,
  output logic                 o_plus,
  output logic                 o_minus,
  output logic                 o_pause_p,
  output logic                 o_pause_n,
  output logic                 o_busy
);
  import pcu_pkg::*;

  bridge_pat_t           pend_pat;
  logic [WAIT_CNT_W-1:0] ws_cnt;
  leg_t                  nxt_top;
  leg_t                  nxt_bot;
  logic [3:0]            nxt_ind;
  logic [3:0]            ind;  // {pause_n, pause_p, minus, plus}

  assign {o_pause_n, o_pause_p, o_minus, o_plus} = ind;

  always_comb begin
    nxt_top = '0;
    nxt_bot = '0;
    nxt_ind = '0;
    case (pend_pat)
      PAT_PLUS: begin
        nxt_top = 4'b0001;
        nxt_bot = 4'b0010;
        nxt_ind = 4'b0001;
      end
      PAT_MINUS: begin
        nxt_top = 4'b0010;
        nxt_bot = 4'b0001;
        nxt_ind = 4'b0010;
      end
      PAT_BAL_P: begin
        nxt_top = 4'b0100;
        nxt_bot = 4'b1000;
        nxt_ind = 4'b0100;
      end
      PAT_BAL_N: begin
        nxt_top = 4'b1000;
        nxt_bot = 4'b0100;
        nxt_ind = 4'b1000;
      end
      default: ;  // Bridge off
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pend_pat <= PAT_OFF;
      ws_cnt   <= '0;
      o_busy   <= 1'b0;
      o_top    <= '0;
      o_bot    <= '0;
      ind      <= '0;
    end else if (i_shutdown || i_fault) begin
      pend_pat <= PAT_OFF;  // Drop anything pending
      ws_cnt   <= '0;
      o_busy   <= 1'b0;
      o_top    <= '0;
      o_bot    <= '0;
      ind      <= '0;
    end else if (i_load) begin
      pend_pat <= i_pat;
      ws_cnt   <= WAIT_CNT_W'(WAIT_STATES - 1);
      o_busy   <= (i_pat != PAT_OFF);  // No dead time needed to switch off
      o_top    <= '0;
      o_bot    <= '0;
      ind      <= '0;
    end else if (o_busy) begin
      if (ws_cnt == '0) begin
        o_busy <= 1'b0;
        o_top  <= nxt_top;
        o_bot  <= nxt_bot;
        ind    <= nxt_ind;
      end else begin
        ws_cnt <= ws_cnt - 1'b1;  // Dead time
      end
    end
  end

endmodule

//--- source/charge_sequencer.sv
module charge_sequencer (
  input  logic clk,
  input  logic rstn,
  input  logic i_start,
  input  logic i_shutdown,
  input  logic i_fault,
  output logic o_charge,
  output logic o_ch,
  output logic o_st,
  output logic o_fan,
  output logic o_ready,
  output logic o_ramping
);
  import pcu_pkg::*;

  logic [STEP_W-1:0]     step;
  logic [RAMP_CNT_W-1:0] step_tmr;
  logic [PWM_W-1:0]      pwm_cnt;
  logic [PWM_W-1:0]      duty;
  logic                  step_end;

  assign step_end = (step_tmr == RAMP_CNT_W'(RAMP_STEP_CYCLES - 1));
  assign o_ch     = o_charge & ((pwm_cnt < duty) | (&duty));  // Full duty never drops

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      step      <= '0;
      step_tmr  <= '0;
      pwm_cnt   <= '0;
      duty      <= '0;
      o_charge  <= 1'b0;
      o_st      <= 1'b0;
      o_fan     <= 1'b0;
      o_ready   <= 1'b0;
      o_ramping <= 1'b0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;  // Free running
      if (i_fault || i_shutdown) begin
        o_fan     <= i_fault;  // Keep cooling on a fault
        step      <= '0;
        step_tmr  <= '0;
        duty      <= '0;
        o_charge  <= 1'b0;
        o_st      <= 1'b0;
        o_ready   <= 1'b0;
        o_ramping <= 1'b0;
      end else if (i_start) begin
        o_fan     <= 1'b1;
        step      <= '0;
        step_tmr  <= '0;
        duty      <= DUTY_TABLE[0];
        o_charge  <= 1'b1;
        o_st      <= 1'b0;
        o_ready   <= 1'b0;
        o_ramping <= 1'b1;
      end else if (o_ramping) begin
        step_tmr <= step_end ? '0 : step_tmr + 1'b1;
        if (step_end) begin
          if (step < STEP_W'(RAMP_STEPS - 1)) begin
            step <= step + 1'b1;
            duty <= DUTY_TABLE[step + 1'b1];  // Next ramp entry
          end else if (step == STEP_W'(RAMP_STEPS - 1)) begin
            step <= step + 1'b1;
            o_st <= 1'b1;  // Ramp done, one settle step left
          end else begin
            duty      <= '0;
            o_charge  <= 1'b0;
            o_ready   <= 1'b1;
            o_ramping <= 1'b0;
          end
        end
      end
    end
  end

endmodule

//--- source/cmd_decoder.sv
module cmd_decoder (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic [pcu_pkg::BUS_W-1:0] i_bus,
  input  logic                      i_strobe,
  input  logic                      i_fault,
  input  logic                      i_busy,
  input  logic                      i_ready,
  input  logic                      i_ramping,
  output logic                      o_bridge_load,
  output pcu_pkg::bridge_pat_t      o_bridge_pat,
  output logic                      o_start_req,
  output logic                      o_shutdown
);
  import pcu_pkg::*;

  bus_cmd_t cmd;
  logic     strobe_q;
  logic     strobe_fall;
  logic     start_armed;
  logic     pat_ok;

  assign cmd         = bus_cmd_t'(i_bus);
  assign strobe_fall = strobe_q & ~i_strobe;
  assign pat_ok      = i_ready & ~i_ramping;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      strobe_q      <= 1'b0;
      start_armed   <= 1'b0;
      o_bridge_load <= 1'b0;
      o_bridge_pat  <= PAT_OFF;
      o_start_req   <= 1'b0;
      o_shutdown    <= 1'b0;
    end else begin
      strobe_q      <= i_strobe;
      o_bridge_load <= 1'b0;  // Pulses last one cycle
      o_start_req   <= 1'b0;
      o_shutdown    <= 1'b0;
      if (i_fault) begin
        start_armed <= 1'b0;
      end else if (strobe_fall) begin
        start_armed <= 1'b0;  // Any strobe ends the start prefix
        if (cmd == CMD_SHUTDOWN) begin
          o_shutdown <= 1'b1;
        end else if (start_armed) begin
          o_start_req <= (cmd == CMD_PAUSE);  // Second half of start
        end else if (!i_busy) begin
          case (cmd)
            CMD_PAUSE: begin
              o_bridge_load <= ~i_ramping;
              o_bridge_pat  <= PAT_OFF;
            end
            CMD_PLUS: begin
              o_bridge_load <= pat_ok;
              o_bridge_pat  <= PAT_PLUS;
            end
            CMD_MINUS: begin
              o_bridge_load <= pat_ok;
              o_bridge_pat  <= PAT_MINUS;
            end
            CMD_BALLAST_P: begin
              o_bridge_load <= pat_ok;
              o_bridge_pat  <= PAT_BAL_P;
            end
            CMD_BALLAST_N: begin
              o_bridge_load <= pat_ok;
              o_bridge_pat  <= PAT_BAL_N;
            end
            CMD_START: start_armed <= ~i_ramping;
            default: ;  // Reserved code
          endcase
        end
      end
    end
  end

endmodule

//--- source/fault_latch.sv
module fault_latch (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic [pcu_pkg::N_FAULT-1:0] i_fault_raw,
  output logic                        o_fault,
  output logic                        o_break,
  output logic                        o_stop,
  output logic                        o_avv,
  output logic                        o_avi,
  output logic                        o_td,
  output pcu_pkg::leg_t               o_erbd
);
  import pcu_pkg::*;

  logic [N_FAULT-1:0]      active;
  logic [FILTER_CNT_W-1:0] settle_cnt;
  logic                    settled;

  // Filter outputs start low, so the active-low lines look faulty until they settle
  assign settled = (settle_cnt == FILTER_CNT_W'(FILTER_LEN + 1));
  assign active  = {i_fault_raw[N_FAULT-1], ~i_fault_raw[N_FAULT-2:0]} & {N_FAULT{settled}};
  assign o_break = o_fault;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      settle_cnt <= '0;
      o_fault    <= 1'b0;
      o_stop     <= 1'b0;
      o_avv      <= 1'b0;
      o_avi      <= 1'b0;
      o_td       <= 1'b0;
      o_erbd     <= '0;
    end else begin
      if (!settled) begin
        settle_cnt <= settle_cnt + 1'b1;
      end
      o_fault <= o_fault | (|active);  // Held until reset
      o_erbd  <= o_erbd | active[N_LEG-1:0];  // Driver errors per leg
      o_avv   <= o_avv | active[4];
      o_avi   <= o_avi | active[5];
      o_stop  <= o_stop | active[6];
      o_td    <= o_td | active[7];  // Thermal, active high pin
    end
  end

endmodule

//--- source/input_filter.sv
module input_filter #(
  parameter int WIDTH = 1
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic [WIDTH-1:0] i_raw,
  output logic [WIDTH-1:0] o_clean
);
  import pcu_pkg::*;

  logic [FILTER_CNT_W-1:0] run_cnt [WIDTH];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_clean <= '0;
      for (int i = 0; i < WIDTH; i++) begin
        run_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < WIDTH; i++) begin
        if (i_raw[i] == o_clean[i]) begin
          run_cnt[i] <= '0;  // Glitch or no change
        end else if (run_cnt[i] == FILTER_CNT_W'(FILTER_LEN - 1)) begin
          o_clean[i] <= i_raw[i];  // Held long enough
          run_cnt[i] <= '0;
        end else begin
          run_cnt[i] <= run_cnt[i] + 1'b1;
        end
      end
    end
  end

endmodule

//--- source/pcu_pkg.sv
package pcu_pkg;

  localparam int BUS_W = 3;

  typedef enum logic [BUS_W-1:0] {
    CMD_PAUSE     = 3'd0,
    CMD_PLUS      = 3'd1,
    CMD_MINUS     = 3'd2,
    CMD_BALLAST_P = 3'd3,
    CMD_BALLAST_N = 3'd4,
    CMD_START     = 3'd5,
    CMD_SHUTDOWN  = 3'd6,
    CMD_RESERVED  = 3'd7
  } bus_cmd_t;

  localparam int N_LEG = 4;

  typedef logic [N_LEG-1:0] leg_t;  // One bit per switch

  typedef enum logic [2:0] {
    PAT_OFF,
    PAT_PLUS,
    PAT_MINUS,
    PAT_BAL_P,
    PAT_BAL_N
  } bridge_pat_t;

  localparam int FILTER_LEN   = 8;
  localparam int FILTER_CNT_W = $clog2(FILTER_LEN + 2);  // Also covers the fault settle count

  localparam int WAIT_STATES = 4;
  localparam int WAIT_CNT_W  = $clog2(WAIT_STATES + 1);

  localparam int PWM_W            = 16;
  localparam int RAMP_STEPS       = 15;
  localparam int STEP_W           = $clog2(RAMP_STEPS + 1);  // Table steps plus final wait
  localparam int RAMP_STEP_CYCLES = 256;  // Simulation scale, one second in the field
  localparam int RAMP_CNT_W       = $clog2(RAMP_STEP_CYCLES);

  // Roughly doubling duty per step, last one fully on
  localparam logic [PWM_W-1:0] DUTY_TABLE [RAMP_STEPS] = '{
    16'd5,    16'd11,   16'd23,   16'd46,   16'd90,
    16'd174,  16'd338,  16'd654,  16'd1264, 16'd2441,
    16'd4715, 16'd9105, 16'd17580, 16'd33943, 16'hFFFF
  };

  localparam int N_FAULT = 8;  // err_dr[3:0], err_u, err_i, stop_k, bt

endpackage

//--- source/pcu_top.sv
module pcu_top (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic [pcu_pkg::BUS_W-1:0] i_bus,
  input  logic                      i_bus_clk,
  input  pcu_pkg::leg_t             i_err_dr_n,
  input  logic                      i_err_u_n,
  input  logic                      i_err_i_n,
  input  logic                      i_stop_k_n,
  input  logic                      i_bt,
  output pcu_pkg::leg_t             o_top,
  output pcu_pkg::leg_t             o_bot,
  output logic                      o_plus,
  output logic                      o_minus,
  output logic                      o_pause_p,
  output logic                      o_pause_n,
  output logic                      o_st,
  output logic                      o_charge,
  output logic                      o_ch,
  output logic                      o_fan,
  output logic                      o_break,
  output logic                      o_stop,
  output logic                      o_avv,
  output logic                      o_avi,
  output logic                      o_td,
  output pcu_pkg::leg_t             o_erbd
);
  import pcu_pkg::*;

  logic [BUS_W:0]     bus_clean;  // Strobe on top
  logic [N_FAULT-1:0] fault_clean;
  logic               fault;
  logic               busy;
  logic               ready;
  logic               ramping;
  logic               bridge_load;
  bridge_pat_t        bridge_pat;
  logic               start_req;
  logic               shutdown;

  input_filter #(.WIDTH(BUS_W + 1)) u_bus_filter (
    .clk    (clk),
    .rstn   (rstn),
    .i_raw  ({i_bus_clk, i_bus}),
    .o_clean(bus_clean)
  );

  input_filter #(.WIDTH(N_FAULT)) u_fault_filter (
    .clk    (clk),
    .rstn   (rstn),
    .i_raw  ({i_bt, i_stop_k_n, i_err_i_n, i_err_u_n, i_err_dr_n}),
    .o_clean(fault_clean)
  );

  fault_latch u_fault (
    .clk        (clk),
    .rstn       (rstn),
    .i_fault_raw(fault_clean),
    .o_fault    (fault),
    .o_break    (o_break),
    .o_stop     (o_stop),
    .o_avv      (o_avv),
    .o_avi      (o_avi),
    .o_td       (o_td),
    .o_erbd     (o_erbd)
  );

  cmd_decoder u_dec (
    .clk          (clk),
    .rstn         (rstn),
    .i_bus        (bus_clean[BUS_W-1:0]),
    .i_strobe     (bus_clean[BUS_W]),
    .i_fault      (fault),
    .i_busy       (busy),
    .i_ready      (ready),
    .i_ramping    (ramping),
    .o_bridge_load(bridge_load),
    .o_bridge_pat (bridge_pat),
    .o_start_req  (start_req),
    .o_shutdown   (shutdown)
  );

  bridge_driver u_bridge (
    .clk       (clk),
    .rstn      (rstn),
    .i_load    (bridge_load),
    .i_pat     (bridge_pat),
    .i_shutdown(shutdown),
    .i_fault   (fault),
    .o_top     (o_top),
    .o_bot     (o_bot),
    .o_plus    (o_plus),
    .o_minus   (o_minus),
    .o_pause_p (o_pause_p),
    .o_pause_n (o_pause_n),
    .o_busy    (busy)
  );

  charge_sequencer u_charge (
    .clk       (clk),
    .rstn      (rstn),
    .i_start   (start_req),
    .i_shutdown(shutdown),
    .i_fault   (fault),
    .o_charge  (o_charge),
    .o_ch      (o_ch),
    .o_st      (o_st),
    .o_fan     (o_fan),
    .o_ready   (ready),
    .o_ramping (ramping)
  );

endmodule

//--- tb/pcu_checker.sv
module pcu_checker (
  input  logic       clk,
  input  logic       i_go,
  input  logic [3:0] i_beh,
  input  logic [7:0] i_mask,
  input  logic [3:0] i_exp_top,
  input  logic [3:0] i_exp_bot,
  input  logic [7:0] i_exp_ind,
  input  logic [3:0] i_top,
  input  logic [3:0] i_bot,
  input  logic       i_plus,
  input  logic       i_minus,
  input  logic       i_pause_p,
  input  logic       i_pause_n,
  input  logic       i_st,
  input  logic       i_charge,
  input  logic       i_ch,
  input  logic       i_fan,
  input  logic       i_break,
  input  logic       i_stop,
  input  logic       i_avv,
  input  logic       i_avi,
  input  logic       i_td,
  input  logic [3:0] i_erbd,
  output int         o_done,
  output int         o_pass,
  output int         o_fail,
  output int         o_errors
);
  timeunit 1ns;
  timeprecision 100ps;
  import pcu_pkg::*;

  localparam int B_RESET = 0, B_QUIET = 1, B_RAMP = 2, B_PAT = 3;
  localparam int B_CLEAR = 4, B_SHUT = 5, B_FAULT = 6, B_LATCHED = 7;
  localparam int P_ON = 0, P_ST = 1, P_CHG_LOW = 2, P_ZERO = 3;
  localparam int P_EXP = 4, P_SHUT = 5, P_FAULT = 6;
  localparam int RAMP_LIMIT = 17 * RAMP_STEP_CYCLES;
  localparam int WAIT_LIMIT = 400;
  localparam int QUIET_CYCLES = 200;

  logic [3:0] ind;
  logic [7:0] sticky;
  logic       bridge_zero;
  int         row_err;
  int         ch_hi;
  int         ch_lo;

  assign ind         = {i_pause_n, i_pause_p, i_minus, i_plus};
  assign sticky      = {i_td, i_stop, i_avi, i_avv, i_erbd};  // Same order as fault mask
  assign bridge_zero = (i_top == 4'h0) && (i_bot == 4'h0) && (ind == 4'h0);

  function automatic logic phase_met(input int ph);
    case (ph)
      P_ON:      return i_fan && i_charge;
      P_ST:      return i_st;
      P_CHG_LOW: return !i_charge;
      P_ZERO:    return bridge_zero;
      P_EXP:     return i_top == i_exp_top && i_bot == i_exp_bot && ind == i_exp_ind[3:0];
      P_SHUT:    return !i_st && !i_fan && bridge_zero;
      default:   return i_break && i_fan && bridge_zero && !i_st && (sticky & i_mask) == i_mask;
    endcase
  endfunction

  task automatic wait_phase(input int ph, input int limit, input string what);
    int n;
    n = 0;
    while (!phase_met(ph) && n < limit) begin
      @(negedge clk);  // Outputs settled here
      n++;
      if (i_charge && i_ch) ch_hi++;
      if (i_charge && !i_ch) ch_lo++;
    end
    if (!phase_met(ph)) begin
      $display("row %0d: timed out waiting for %s", o_done, what);
      row_err++;
    end
  endtask

  task automatic compare(input string name, input logic [7:0] exp, input logic [7:0] got);
    if (exp !== got) begin
      $display("CHECK FAILED %s: expected 0x%h, got 0x%h", name, exp, got);
      row_err++;
    end
  endtask

  // Bridge must hold its value and no charge may start
  task automatic quiet_window(input logic all_low, input logic latched);
    logic [7:0] exp_ind;
    exp_ind = latched ? 8'h00 : 8'(i_exp_ind[3:0]);  // Latched rows carry sticky bits in ind
    for (int n = 0; n < QUIET_CYCLES && row_err == 0; n++) begin
      @(negedge clk);
      compare("o_top", 8'(i_exp_top), 8'(i_top));
      compare("o_bot", 8'(i_exp_bot), 8'(i_bot));
      compare("indicators", exp_ind, 8'(ind));
      compare("o_charge", 8'h00, 8'(i_charge));
      if (all_low) begin
        compare("o_st", 8'h00, 8'(i_st));
        compare("o_fan", 8'h00, 8'(i_fan));
        compare("o_ch", 8'h00, 8'(i_ch));
        compare("o_break", 8'h00, 8'(i_break));
        compare("sticky", 8'h00, sticky);
      end
      if (latched) begin
        compare("o_break", 8'h01, 8'(i_break));
        compare("o_fan", 8'h01, 8'(i_fan));
        compare("sticky", i_exp_ind, sticky);
      end
    end
  endtask

  task automatic run_row();
    row_err = 0;
    ch_hi   = 0;
    ch_lo   = 0;
    case (int'(i_beh))
      B_RESET:   quiet_window(1'b1, 1'b0);
      B_QUIET:   quiet_window(1'b0, 1'b0);
      B_LATCHED: quiet_window(1'b0, 1'b1);
      B_RAMP: begin
        wait_phase(P_ON, RAMP_LIMIT, "fan and charge on");
        wait_phase(P_ST, RAMP_LIMIT, "o_st high");
        wait_phase(P_CHG_LOW, 2 * RAMP_STEP_CYCLES, "o_charge low");
        if (ch_hi == 0 || ch_lo == 0) begin
          $display("row %0d: o_ch was not both on and off during the ramp", o_done);
          row_err++;
        end
      end
      B_PAT: begin
        wait_phase(P_ZERO, WAIT_LIMIT, "bridge off during dead time");
        wait_phase(P_EXP, WAIT_LIMIT, "new bridge pattern");
        compare("o_top", 8'(i_exp_top), 8'(i_top));
        compare("o_bot", 8'(i_exp_bot), 8'(i_bot));
        compare("indicators", 8'(i_exp_ind[3:0]), 8'(ind));
      end
      B_CLEAR: wait_phase(P_ZERO, WAIT_LIMIT, "bridge off");
      B_SHUT:  wait_phase(P_SHUT, WAIT_LIMIT, "shutdown state");
      B_FAULT: begin
        wait_phase(P_FAULT, WAIT_LIMIT, "fault state");
        compare("sticky", i_exp_ind, sticky);
      end
      default: begin
        $display("row %0d: unknown behavior id %0d", o_done, i_beh);
        row_err++;
      end
    endcase
    if (row_err == 0) begin
      $display("row %0d behavior %0d passed", o_done, i_beh);
      o_pass++;
    end else begin
      $display("row %0d behavior %0d failed with %0d errors", o_done, i_beh, row_err);
      o_fail++;
    end
    o_errors += row_err;
    o_done++;
  endtask

  initial begin
    o_done   = 0;
    o_pass   = 0;
    o_fail   = 0;
    o_errors = 0;
    forever begin
      @(negedge clk);
      if (i_go) run_row();
    end
  end

endmodule

//--- tb/tb_pcu.sv
module tb_pcu;
  timeunit 1ns;
  timeprecision 100ps;
  import pcu_pkg::*;

  localparam int B_RESET = 0, B_QUIET = 1, B_RAMP = 2, B_PAT = 3;
  localparam int B_CLEAR = 4, B_SHUT = 5, B_FAULT = 6, B_LATCHED = 7;
  localparam int N_ROWS = 23;
  localparam int ROW_TIMEOUT = 20 * RAMP_STEP_CYCLES;

  typedef struct packed {
    logic       pre;  // Send the start prefix first
    logic [2:0] code;
    logic [7:0] mask;
    logic [3:0] beh;
    logic [3:0] top;
    logic [3:0] bot;
    logic [7:0] ind;
  } row_t;

  // Fault mask order {bt, stop_k, err_i, err_u, err_dr[3:0]}
  localparam row_t ROWS [N_ROWS] = '{
    '{1'b0, 3'd1, 8'h00, 4'(B_RESET),   4'h0, 4'h0, 8'h00},
    '{1'b1, 3'd0, 8'h00, 4'(B_RAMP),    4'h0, 4'h0, 8'h00},
    '{1'b0, 3'd1, 8'h00, 4'(B_PAT),     4'h1, 4'h2, 8'h01},
    '{1'b0, 3'd2, 8'h00, 4'(B_PAT),     4'h2, 4'h1, 8'h02},
    '{1'b0, 3'd3, 8'h00, 4'(B_PAT),     4'h4, 4'h8, 8'h04},
    '{1'b0, 3'd4, 8'h00, 4'(B_PAT),     4'h8, 4'h4, 8'h08},
    '{1'b0, 3'd0, 8'h00, 4'(B_CLEAR),   4'h0, 4'h0, 8'h00},
    '{1'b1, 3'd1, 8'h00, 4'(B_QUIET),   4'h0, 4'h0, 8'h00},
    '{1'b0, 3'd1, 8'h00, 4'(B_PAT),     4'h1, 4'h2, 8'h01},
    '{1'b0, 3'd6, 8'h00, 4'(B_SHUT),    4'h0, 4'h0, 8'h00},
    '{1'b0, 3'd1, 8'h00, 4'(B_QUIET),   4'h0, 4'h0, 8'h00},
    '{1'b1, 3'd0, 8'h00, 4'(B_RAMP),    4'h0, 4'h0, 8'h00},
    '{1'b0, 3'd1, 8'h00, 4'(B_PAT),     4'h1, 4'h2, 8'h01},
    '{1'b0, 3'd7, 8'h01, 4'(B_FAULT),   4'h0, 4'h0, 8'h01},
    '{1'b0, 3'd7, 8'h02, 4'(B_FAULT),   4'h0, 4'h0, 8'h03},
    '{1'b0, 3'd7, 8'h04, 4'(B_FAULT),   4'h0, 4'h0, 8'h07},
    '{1'b0, 3'd7, 8'h08, 4'(B_FAULT),   4'h0, 4'h0, 8'h0F},
    '{1'b0, 3'd7, 8'h10, 4'(B_FAULT),   4'h0, 4'h0, 8'h1F},
    '{1'b0, 3'd7, 8'h20, 4'(B_FAULT),   4'h0, 4'h0, 8'h3F},
    '{1'b0, 3'd7, 8'h40, 4'(B_FAULT),   4'h0, 4'h0, 8'h7F},
    '{1'b0, 3'd7, 8'h80, 4'(B_FAULT),   4'h0, 4'h0, 8'hFF},
    '{1'b0, 3'd1, 8'h00, 4'(B_LATCHED), 4'h0, 4'h0, 8'hFF},
    '{1'b1, 3'd0, 8'h00, 4'(B_LATCHED), 4'h0, 4'h0, 8'hFF}
  };

  logic       clk;
  logic       rstn;
  logic [2:0] i_bus;
  logic       i_bus_clk;
  leg_t       i_err_dr_n;
  logic       i_err_u_n, i_err_i_n, i_stop_k_n, i_bt;
  leg_t       o_top, o_bot, o_erbd;
  logic       o_plus, o_minus, o_pause_p, o_pause_n, o_st, o_charge, o_ch;
  logic       o_fan, o_break, o_stop, o_avv, o_avi, o_td;
  logic       go;
  row_t       cur;
  logic       timed_out;
  int         done_cnt, pass_cnt, fail_cnt, err_cnt;

  pcu_top uut (.*);

  pcu_checker u_check (
    .clk(clk), .i_go(go), .i_beh(cur.beh), .i_mask(cur.mask),
    .i_exp_top(cur.top), .i_exp_bot(cur.bot), .i_exp_ind(cur.ind),
    .i_top(o_top), .i_bot(o_bot), .i_plus(o_plus), .i_minus(o_minus),
    .i_pause_p(o_pause_p), .i_pause_n(o_pause_n), .i_st(o_st), .i_charge(o_charge),
    .i_ch(o_ch), .i_fan(o_fan), .i_break(o_break), .i_stop(o_stop), .i_avv(o_avv),
    .i_avi(o_avi), .i_td(o_td), .i_erbd(o_erbd),
    .o_done(done_cnt), .o_pass(pass_cnt), .o_fail(fail_cnt), .o_errors(err_cnt)
  );

  always #20 clk = ~clk;

  task automatic drive_faults(input logic [7:0] mask);
    i_err_dr_n = ~mask[3:0];  // Pins are active low except bt
    i_err_u_n  = ~mask[4];
    i_err_i_n  = ~mask[5];
    i_stop_k_n = ~mask[6];
    i_bt       = mask[7];
  endtask

  task automatic drive_level(input logic [2:0] code, input logic strobe);
    @(posedge clk);
    #2;
    i_bus     = code;
    i_bus_clk = strobe;
    repeat (2 * FILTER_LEN - 1) @(posedge clk);
  endtask

  task automatic send_cmd(input logic [2:0] code);
    drive_level(code, 1'b1);
    drive_level(code, 1'b0);  // Decoder acts on this fall
    drive_level(code, 1'b1);
  endtask

  task automatic wait_row_done(input int idx);
    int n;
    n = 0;
    while (done_cnt <= idx && n < ROW_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (done_cnt <= idx) begin
      $display("row %0d never finished, checker timed out", idx);
      timed_out = 1'b1;
    end
  endtask

  initial begin
    clk       = 1'b0;
    rstn      = 1'b0;
    i_bus     = '0;
    i_bus_clk = 1'b1;
    go        = 1'b0;
    cur       = '0;
    timed_out = 1'b0;
    drive_faults(8'h00);
    repeat (5) @(posedge clk);
    #2 rstn = 1'b1;
    for (int i = 0; i < N_ROWS && !timed_out; i++) begin
      @(posedge clk);
      #2;
      cur = ROWS[i];
      drive_faults(cur.mask);
      go = 1'b1;
      @(posedge clk);
      #2 go = 1'b0;
      if (cur.pre) send_cmd(3'(CMD_START));
      send_cmd(cur.code);
      wait_row_done(i);
      #2 drive_faults(8'h00);  // Release, sticky bits must hold
    end
    $display("rows passed %0d, rows failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0 && !timed_out) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
